// ==== logic/la_defines.svh ====
`ifndef LA_DEFINES_SVH
`define LA_DEFINES_SVH

// capture buffer
`define LA_DEPTH 1024        // entries, power of two so addresses wrap on their own

// display geometry
`define LA_LANE_H 8          // rows per channel lane
`define LA_GRID_STEP 16      // grid pitch in pixels

// overlay colours, packed r g b
`define LA_GRID_COLOR 24'h404040  // dark grey
`define LA_WAVE_COLOR 24'hff0000  // red trace

`endif

// ==== logic/la_capture_pkg.sv ====
`default_nettype none

`include "la_defines.svh"

package la_capture_pkg;

  typedef logic [7:0] sample_t;                        // one bit per probe channel
  typedef logic [$clog2(`LA_DEPTH)-1:0] addr_t;        // buffer address, wraps at depth
  typedef logic [2:0] chan_t;                          // probe channel index
  typedef logic [3:0] rate_t;                          // divide by 2**rate

  // trigger kinds, unknown codes fall back to TRIG_NOW
  typedef enum logic [2:0] {
    TRIG_NOW  = 3'd0,
    TRIG_RISE = 3'd1,
    TRIG_FALL = 3'd2,
    TRIG_HIGH = 3'd3,
    TRIG_LOW  = 3'd4
  } trig_mode_t;

  typedef enum logic [2:0] {
    CAP_IDLE,    // waiting for arm
    CAP_PRE,     // filling pre-trigger window
    CAP_SEARCH,  // testing each sample
    CAP_POST,    // filling the rest of the buffer
    CAP_DONE     // record complete
  } cap_state_t;

endpackage

`default_nettype wire

// ==== logic/la_video_pkg.sv ====
`default_nettype none

package la_video_pkg;

  // 8 bits each, r in the top byte
  typedef logic [23:0] pixel_t;

  // column or row position inside the active area
  typedef logic [10:0] coord_t;

endpackage

`default_nettype wire

// ==== logic/la_rate_div.sv ====
`default_nettype none

module la_rate_div (
  input  wire                    i_sys_clk,
  input  wire                    i_rst_n,
  input  wire                    i_sync,      // arm strobe, restarts the count
  input  wire la_capture_pkg::rate_t i_freq_sel,
  output logic                   o_clken
);

  logic [15:0] cnt;        // edges since the last arm, for the coming cycle
  logic [15:0] cnt_nxt;
  logic [15:0] mask;       // low freq_sel bits

  // the count seen during the cycle ending at edge m is m itself
  assign cnt_nxt = i_sync ? 16'd1 : cnt + 16'd1;
  assign mask    = (16'd1 << i_freq_sel) - 16'd1;

  always_ff @(posedge i_sys_clk) begin
    if (!i_rst_n) begin
      cnt     <= 16'd0;
      o_clken <= 1'b0;
    end else begin
      cnt     <= cnt_nxt;
      // strobe when the low bits wrap to zero
      o_clken <= ((cnt_nxt & mask) == 16'd0);
    end
  end

endmodule

`default_nettype wire

// ==== logic/la_sample_ctrl.sv ====
`default_nettype none

`include "la_defines.svh"

module la_sample_ctrl (
  input  wire                          i_sys_clk,
  input  wire                          i_rst_n,
  input  wire                          i_clken,       // sample strobe
  input  wire                          i_trigger_en,  // arm, also restarts a capture
  input  wire la_capture_pkg::sample_t i_data_in,
  input  wire la_capture_pkg::chan_t   i_chn_sel,
  input  wire [2:0]                    i_mode_sel,
  input  wire la_capture_pkg::addr_t   i_pre_num,     // samples kept before trigger
  output logic                         o_wr_en,
  output la_capture_pkg::addr_t        o_wr_addr,
  output la_capture_pkg::sample_t      o_wr_data,
  output la_capture_pkg::addr_t        o_start_addr,  // oldest sample of the record
  output logic                         o_finished
);

  la_capture_pkg::cap_state_t state;
  la_capture_pkg::trig_mode_t mode;
  la_capture_pkg::addr_t      wr_ptr;     // next buffer slot
  la_capture_pkg::addr_t      post_cnt;   // samples still to write after trigger
  la_capture_pkg::addr_t      post_len;
  logic                       prev_bit;   // selected channel in last written sample
  logic                       prev_vld;   // no edge before the first sample
  logic                       cur_bit;
  logic                       trig_hit;

  assign cur_bit  = i_data_in[i_chn_sel];
  assign post_len = la_capture_pkg::addr_t'(`LA_DEPTH - 1) - i_pre_num;

  // mode decode, spare codes act as immediate
  always_comb begin
    case (i_mode_sel)
      3'd1:    mode = la_capture_pkg::TRIG_RISE;
      3'd2:    mode = la_capture_pkg::TRIG_FALL;
      3'd3:    mode = la_capture_pkg::TRIG_HIGH;
      3'd4:    mode = la_capture_pkg::TRIG_LOW;
      default: mode = la_capture_pkg::TRIG_NOW;
    endcase
  end

  always_comb begin
    case (mode)
      la_capture_pkg::TRIG_RISE: trig_hit = prev_vld && !prev_bit && cur_bit;
      la_capture_pkg::TRIG_FALL: trig_hit = prev_vld && prev_bit && !cur_bit;
      la_capture_pkg::TRIG_HIGH: trig_hit = cur_bit;
      la_capture_pkg::TRIG_LOW:  trig_hit = !cur_bit;
      default:                   trig_hit = 1'b1;
    endcase
  end

  // write port, address and data valid with the strobe
  always_ff @(posedge i_sys_clk) begin
    if (i_clken) begin
      o_wr_addr <= wr_ptr;
      o_wr_data <= i_data_in;
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (!i_rst_n) begin
      state        <= la_capture_pkg::CAP_IDLE;
      o_wr_en      <= 1'b0;
      o_finished   <= 1'b0;
      o_start_addr <= '0;
      wr_ptr       <= '0;
      post_cnt     <= '0;
      prev_bit     <= 1'b0;
      prev_vld     <= 1'b0;
    end else if (i_trigger_en) begin
      // arm from any state
      state      <= (i_pre_num == '0) ? la_capture_pkg::CAP_SEARCH : la_capture_pkg::CAP_PRE;
      o_wr_en    <= 1'b0;
      o_finished <= 1'b0;
      wr_ptr     <= '0;
      prev_vld   <= 1'b0;
    end else begin
      o_wr_en <= 1'b0;                    // single cycle write pulse
      case (state)
        la_capture_pkg::CAP_PRE: begin
          if (i_clken) begin
            o_wr_en  <= 1'b1;
            wr_ptr   <= wr_ptr + 1'b1;
            prev_bit <= cur_bit;
            prev_vld <= 1'b1;
            if (wr_ptr == i_pre_num - 1'b1) state <= la_capture_pkg::CAP_SEARCH;
          end
        end
        la_capture_pkg::CAP_SEARCH: begin
          if (i_clken) begin
            o_wr_en  <= 1'b1;
            wr_ptr   <= wr_ptr + 1'b1;
            prev_bit <= cur_bit;
            prev_vld <= 1'b1;
            if (trig_hit) begin
              o_start_addr <= wr_ptr - i_pre_num;   // wraps modulo depth
              post_cnt     <= post_len;
              // full pre-trigger window leaves nothing to follow
              state <= (post_len == '0) ? la_capture_pkg::CAP_DONE : la_capture_pkg::CAP_POST;
            end
          end
        end
        la_capture_pkg::CAP_POST: begin
          if (i_clken) begin
            o_wr_en  <= 1'b1;
            wr_ptr   <= wr_ptr + 1'b1;
            post_cnt <= post_cnt - 1'b1;
            if (post_cnt == la_capture_pkg::addr_t'(1)) state <= la_capture_pkg::CAP_DONE;
          end
        end
        la_capture_pkg::CAP_DONE: begin
          o_finished <= 1'b1;             // one cycle after the last write
        end
        default: begin
          state <= la_capture_pkg::CAP_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/la_grid_overlay.sv ====
`default_nettype none

`include "la_defines.svh"

module la_grid_overlay (
  input  wire                         i_pix_clk,
  input  wire                         i_rst_n,
  input  wire                         i_hs,
  input  wire                         i_vs,      // active high, restarts the row count
  input  wire                         i_de,
  input  wire la_video_pkg::pixel_t   i_pixel,
  output logic                        o_hs,
  output logic                        o_vs,
  output logic                        o_de,
  output la_video_pkg::pixel_t        o_pixel
);

  la_video_pkg::coord_t col;   // position of the current input pixel
  la_video_pkg::coord_t row;
  logic                 de_d;  // for the end of line edge
  logic                 on_grid;

  // position tracking
  always_ff @(posedge i_pix_clk) begin
    if (!i_rst_n) begin
      col  <= '0;
      row  <= '0;
      de_d <= 1'b0;
    end else begin
      de_d <= i_de;
      col  <= i_de ? col + 1'b1 : '0;     // back to zero outside active video
      if (i_vs)
        row <= '0;
      else if (de_d && !i_de)
        row <= row + 1'b1;                // line finished
    end
  end

  assign on_grid = i_de &&
                   ((col % la_video_pkg::coord_t'(`LA_GRID_STEP)) == '0 ||
                    (row % la_video_pkg::coord_t'(`LA_GRID_STEP)) == '0);

  always_ff @(posedge i_pix_clk) begin
    if (!i_rst_n) begin
      o_hs <= 1'b0;
      o_vs <= 1'b0;
      o_de <= 1'b0;
    end else begin
      o_hs <= i_hs;
      o_vs <= i_vs;
      o_de <= i_de;
    end
  end

  always_ff @(posedge i_pix_clk) begin
    o_pixel <= on_grid ? la_video_pkg::pixel_t'(`LA_GRID_COLOR) : i_pixel;
  end

endmodule

`default_nettype wire

// ==== logic/la_wave_overlay.sv ====
`default_nettype none

`include "la_defines.svh"

module la_wave_overlay (
  input  wire                          i_sys_clk,
  input  wire                          i_pix_clk,
  input  wire                          i_rst_n,
  input  wire                          i_wr_en,       // sys_clk write port
  input  wire la_capture_pkg::addr_t   i_wr_addr,
  input  wire la_capture_pkg::sample_t i_wr_data,
  input  wire la_capture_pkg::addr_t   i_start_addr,  // stable once capture is done
  input  wire                          i_hs,
  input  wire                          i_vs,
  input  wire                          i_de,
  input  wire la_video_pkg::pixel_t    i_pixel,
  output logic                         o_hs,
  output logic                         o_vs,
  output logic                         o_de,
  output la_video_pkg::pixel_t         o_pixel
);

  la_capture_pkg::sample_t mem [`LA_DEPTH];   // capture record

  la_video_pkg::coord_t    col;
  la_video_pkg::coord_t    row;
  logic                    de_d;
  la_capture_pkg::addr_t   rd_addr;

  // stage 1, aligned with the RAM output
  la_capture_pkg::sample_t rd_data;
  la_capture_pkg::chan_t   lane_q;
  la_video_pkg::coord_t    lrow_q;      // row inside the lane
  logic                    in_lanes_q;
  logic                    hs_q, vs_q, de_q;
  la_video_pkg::pixel_t    pix_q;
  logic                    wave_hit;

  // write side lives in the sampling domain
  always_ff @(posedge i_sys_clk) begin
    if (i_wr_en) mem[i_wr_addr] <= i_wr_data;
  end

  // own column and row count, same rules as the grid stage
  always_ff @(posedge i_pix_clk) begin
    if (!i_rst_n) begin
      col  <= '0;
      row  <= '0;
      de_d <= 1'b0;
    end else begin
      de_d <= i_de;
      col  <= i_de ? col + 1'b1 : '0;
      if (i_vs)
        row <= '0;
      else if (de_d && !i_de)
        row <= row + 1'b1;
    end
  end

  // one column per sample, oldest at the left edge
  assign rd_addr = i_start_addr + la_capture_pkg::addr_t'(col);

  always_ff @(posedge i_pix_clk) begin
    rd_data    <= mem[rd_addr];
    lane_q     <= la_capture_pkg::chan_t'(row / la_video_pkg::coord_t'(`LA_LANE_H));
    lrow_q     <= row % la_video_pkg::coord_t'(`LA_LANE_H);
    in_lanes_q <= row < la_video_pkg::coord_t'(8 * `LA_LANE_H);   // eight lanes only
    pix_q      <= i_pixel;
  end

  // high level drawn near the lane top, low level near the bottom
  assign wave_hit = de_q && in_lanes_q &&
                    ((lrow_q == la_video_pkg::coord_t'(1) && rd_data[lane_q]) ||
                     (lrow_q == la_video_pkg::coord_t'(`LA_LANE_H - 2) && !rd_data[lane_q]));

  always_ff @(posedge i_pix_clk) begin
    if (!i_rst_n) begin
      hs_q <= 1'b0;
      vs_q <= 1'b0;
      de_q <= 1'b0;
      o_hs <= 1'b0;
      o_vs <= 1'b0;
      o_de <= 1'b0;
    end else begin
      hs_q <= i_hs;
      vs_q <= i_vs;
      de_q <= i_de;
      o_hs <= hs_q;
      o_vs <= vs_q;
      o_de <= de_q;
    end
  end

  always_ff @(posedge i_pix_clk) begin
    o_pixel <= wave_hit ? la_video_pkg::pixel_t'(`LA_WAVE_COLOR) : pix_q;
  end

endmodule

`default_nettype wire

// ==== logic/la_top.sv ====
`default_nettype none

module la_top (
  input  wire                          i_sys_clk,     // sampling clock
  input  wire                          i_pix_clk,     // video clock
  input  wire                          i_rst_n,
  // capture side, on i_sys_clk
  input  wire la_capture_pkg::sample_t i_data_in,
  input  wire                          i_trigger_en,
  input  wire la_capture_pkg::chan_t   i_chn_sel,
  input  wire [2:0]                    i_mode_sel,
  input  wire la_capture_pkg::rate_t   i_freq_sel,
  input  wire la_capture_pkg::addr_t   i_pre_num,
  // video side, on i_pix_clk
  input  wire                          i_hs,
  input  wire                          i_vs,
  input  wire                          i_de,
  input  wire la_video_pkg::pixel_t    i_pixel,
  output logic                         o_hs,
  output logic                         o_vs,
  output logic                         o_de,
  output la_video_pkg::pixel_t         o_pixel,
  output logic                         o_finished
);

  logic                    clken;
  logic                    wr_en;
  la_capture_pkg::addr_t   wr_addr;
  la_capture_pkg::sample_t wr_data;
  la_capture_pkg::addr_t   start_addr;   // crosses into pix_clk, quasi-static
  logic                    grid_hs;
  logic                    grid_vs;
  logic                    grid_de;
  la_video_pkg::pixel_t    grid_pixel;

  la_rate_div u_rate_div (
    .i_sys_clk  (i_sys_clk),
    .i_rst_n    (i_rst_n),
    .i_sync     (i_trigger_en),   // strobe phase follows the arm
    .i_freq_sel (i_freq_sel),
    .o_clken    (clken)
  );

  la_sample_ctrl u_sample_ctrl (
    .i_sys_clk    (i_sys_clk),
    .i_rst_n      (i_rst_n),
    .i_clken      (clken),
    .i_trigger_en (i_trigger_en),
    .i_data_in    (i_data_in),
    .i_chn_sel    (i_chn_sel),
    .i_mode_sel   (i_mode_sel),
    .i_pre_num    (i_pre_num),
    .o_wr_en      (wr_en),
    .o_wr_addr    (wr_addr),
    .o_wr_data    (wr_data),
    .o_start_addr (start_addr),
    .o_finished   (o_finished)
  );

  // 1 cycle grid stage then 2 cycle wave stage
  la_grid_overlay u_grid_overlay (
    .i_pix_clk (i_pix_clk),
    .i_rst_n   (i_rst_n),
    .i_hs      (i_hs),
    .i_vs      (i_vs),
    .i_de      (i_de),
    .i_pixel   (i_pixel),
    .o_hs      (grid_hs),
    .o_vs      (grid_vs),
    .o_de      (grid_de),
    .o_pixel   (grid_pixel)
  );

  la_wave_overlay u_wave_overlay (
    .i_sys_clk    (i_sys_clk),
    .i_pix_clk    (i_pix_clk),
    .i_rst_n      (i_rst_n),
    .i_wr_en      (wr_en),
    .i_wr_addr    (wr_addr),
    .i_wr_data    (wr_data),
    .i_start_addr (start_addr),
    .i_hs         (grid_hs),
    .i_vs         (grid_vs),
    .i_de         (grid_de),
    .i_pixel      (grid_pixel),
    .o_hs         (o_hs),
    .o_vs         (o_vs),
    .o_de         (o_de),
    .o_pixel      (o_pixel)
  );

endmodule

`default_nettype wire

// ==== test/tb_la_top.sv ====
`default_nettype none

`include "la_defines.svh"

module tb_la_top;

  localparam int MAX_CYC = 16384;        // capture timeout in sys cycles
  localparam int LINE_LEN = 144;         // 128 active plus blanking
  localparam int FRAME_CYC = 74 * LINE_LEN;  // 2 vsync lines, 72 active

  logic clk;
  logic rst_n;
  la_capture_pkg::sample_t data_in;
  logic trigger_en;
  la_capture_pkg::chan_t chn_sel;
  logic [2:0] mode_sel;
  la_capture_pkg::rate_t freq_sel;
  la_capture_pkg::addr_t pre_num;
  logic hs, vs, de;
  la_video_pkg::pixel_t pixel;
  logic o_hs, o_vs, o_de, o_finished;
  la_video_pkg::pixel_t o_pixel;

  logic [31:0] lfsr = 32'h574e830b;
  la_capture_pkg::sample_t drv [MAX_CYC];       // data driven after edge m of the arm
  la_capture_pkg::sample_t samp [MAX_CYC];      // samples in capture order
  la_capture_pkg::sample_t exp_buf [`LA_DEPTH]; // record as seen from start_addr
  int err_val = 0;
  int err_other = 0;
  logic timed_out = 1'b0;                       // capture never finished, stop testing
  logic rec_done = 1'b0;                        // a record is complete, o_finished held

  la_top u_dut (
    .i_sys_clk (clk), .i_pix_clk (clk), .i_rst_n (rst_n),
    .i_data_in (data_in), .i_trigger_en (trigger_en), .i_chn_sel (chn_sel),
    .i_mode_sel (mode_sel), .i_freq_sel (freq_sel), .i_pre_num (pre_num),
    .i_hs (hs), .i_vs (vs), .i_de (de), .i_pixel (pixel),
    .o_hs (o_hs), .o_vs (o_vs), .o_de (o_de), .o_pixel (o_pixel),
    .o_finished (o_finished)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // both domains share it
  end

  // taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic finish_run();
    $display("errors: %0d wrong values, %0d other failures", err_val, err_other);
    if (err_val + err_other == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  endtask

  // trigger rule on sample k
  function automatic logic trig_at(input int k, input logic [2:0] mode, input logic [2:0] c);
    case (mode)
      3'd1: return k >= 1 && !samp[k-1][c] && samp[k][c];
      3'd2: return k >= 1 && samp[k-1][c] && !samp[k][c];
      3'd3: return samp[k][c];
      3'd4: return !samp[k][c];
      default: return 1'b1;
    endcase
  endfunction

  task automatic run_capture(input logic [3:0] rate, input logic [2:0] mode,
                             input logic [2:0] chn, input logic [9:0] pre);
    int m;
    int fin_m;
    int step;
    int hold;
    int nsamp;
    int t;
    int exp_fin;
    logic idle;
    la_capture_pkg::sample_t d;
    // finished record must still be flagged right before the re-arm
    if (rec_done && o_finished !== 1'b1) begin
      $display("ERR o_finished got %h expected %h before re-arm", o_finished, 1'b1);
      err_val++;
    end
    step = 1 << rate;
    hold = (int'(pre) + 16) * step;           // selected channel parked this long
    idle = (mode == 3'd2 || mode == 3'd4);    // fall and low start high
    @(posedge clk);
    freq_sel   <= rate;
    mode_sel   <= mode;
    chn_sel    <= chn;
    pre_num    <= pre;
    trigger_en <= 1'b1;
    @(posedge clk);                           // arm edge E0
    trigger_en <= 1'b0;
    fin_m = -1;
    m = 0;
    while (fin_m < 0 && m < MAX_CYC) begin
      d = la_capture_pkg::sample_t'(rand_bits(8));
      if (mode >= 3'd1 && mode <= 3'd4 && m < hold) d[chn] = idle;
      drv[m] = d;
      data_in <= d;
      @(negedge clk);
      if (m == 0 && o_finished !== 1'b0) begin
        $display("ERR o_finished got %h expected %h after arm", o_finished, 1'b0);
        err_val++;
      end
      if (o_finished == 1'b1) fin_m = m;
      m++;
      if (fin_m < 0) @(posedge clk);
    end
    if (fin_m < 0) begin
      $display("capture did not finish within %0d cycles", MAX_CYC);
      err_other++;
      timed_out = 1'b1;
    end else begin
      rec_done = 1'b1;
      // sample k is the value in front of edge (k+1)*step
      nsamp = m / step;
      for (int k = 0; k < nsamp; k++) samp[k] = drv[(k + 1) * step - 1];
      t = -1;
      for (int k = int'(pre); k < nsamp && t < 0; k++)
        if (trig_at(k, mode, chn)) t = k;
      if (t < 0) begin
        $display("no trigger found in %0d captured samples", nsamp);
        err_other++;
      end else begin
        exp_fin = (t + `LA_DEPTH - int'(pre)) * step + 1;  // one edge after the last write
        if (fin_m != exp_fin) begin
          $display("ERR o_finished rise cycle got %h expected %h", fin_m, exp_fin);
          err_val++;
        end
        for (int x = 0; x < `LA_DEPTH; x++)
          if (t - int'(pre) + x < nsamp) exp_buf[x] = samp[t - int'(pre) + x];
      end
    end
  endtask

  // one 128x72 frame, outputs compared 3 cycles later
  task automatic drive_frame(input logic check_wave);
    logic e_hs [4];
    logic e_vs [4];
    logic e_de [4];
    logic e_chk [4];
    la_video_pkg::pixel_t e_pix [4];
    int e_row [4];
    int e_col [4];
    int line;
    int x;
    int row;
    int s;
    int n;
    logic a_hs, a_vs, a_de;
    logic b;
    la_video_pkg::pixel_t p;
    la_video_pkg::pixel_t ep;
    for (int i = 0; i < FRAME_CYC + 3; i++) begin
      @(posedge clk);
      line = i / LINE_LEN;
      x    = i % LINE_LEN;
      row  = line - 2;
      a_vs = (i < FRAME_CYC) && line < 2;
      a_de = (i < FRAME_CYC) && line >= 2 && x < 128;
      a_hs = (i < FRAME_CYC) && x >= 132 && x < 136;
      p    = la_video_pkg::pixel_t'(rand_bits(24));
      ep   = p;
      if (a_de) begin
        b = exp_buf[x][row / `LA_LANE_H];
        if (row < 8 * `LA_LANE_H &&
            ((row % `LA_LANE_H == 1 && b) || (row % `LA_LANE_H == `LA_LANE_H - 2 && !b)))
          ep = `LA_WAVE_COLOR;
        else if (x % `LA_GRID_STEP == 0 || row % `LA_GRID_STEP == 0)
          ep = `LA_GRID_COLOR;
      end
      hs    <= a_hs;
      vs    <= a_vs;
      de    <= a_de;
      pixel <= p;
      s = i % 4;
      e_hs[s]  = a_hs;
      e_vs[s]  = a_vs;
      e_de[s]  = a_de;
      e_pix[s] = ep;
      e_row[s] = row;
      e_col[s] = x;
      e_chk[s] = !(a_de && row < 8 * `LA_LANE_H && !check_wave);  // no record yet
      @(negedge clk);
      if (i >= 3) begin
        n = (i - 3) % 4;
        if (o_hs !== e_hs[n]) begin
          $display("ERR o_hs got %h expected %h", o_hs, e_hs[n]);
          err_val++;
        end
        if (o_vs !== e_vs[n]) begin
          $display("ERR o_vs got %h expected %h", o_vs, e_vs[n]);
          err_val++;
        end
        if (o_de !== e_de[n]) begin
          $display("ERR o_de got %h expected %h", o_de, e_de[n]);
          err_val++;
        end
        if (e_chk[n] && o_pixel !== e_pix[n]) begin
          $display("ERR o_pixel got %h expected %h at row %0d col %0d",
                   o_pixel, e_pix[n], e_row[n], e_col[n]);
          err_val++;
        end
      end
    end
  endtask

  initial begin
    int fd;
    int ntests;
    string txt;
    logic [31:0] f_rate, f_mode, f_chn, f_pre;
    rst_n      <= 1'b0;
    data_in    <= '0;
    trigger_en <= 1'b0;
    chn_sel    <= '0;
    mode_sel   <= '0;
    freq_sel   <= '0;
    pre_num    <= '0;
    hs         <= 1'b0;
    vs         <= 1'b0;
    de         <= 1'b0;
    pixel      <= '0;
    ntests = 0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (o_finished !== 1'b0 || o_hs !== 1'b0 || o_vs !== 1'b0 || o_de !== 1'b0) begin
      $display("ERR o_finished/o_hs/o_vs/o_de got %h expected %h",
               {o_finished, o_hs, o_vs, o_de}, 4'h0);
      err_val++;
    end
    drive_frame(1'b0);  // grid only, buffer still empty
    fd = $fopen("test/la_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open the pattern file");
      err_other++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        txt = "";
        void'($fgets(txt, fd));
        if (txt.len() > 1 && txt[0] != "#") begin
          if ($sscanf(txt, "%h %h %h %h", f_rate, f_mode, f_chn, f_pre) == 4) begin
            run_capture(f_rate[3:0], f_mode[2:0], f_chn[2:0], f_pre[9:0]);
            if (!timed_out)
              drive_frame(1'b1);
            ntests++;
          end
        end
      end
      $fclose(fd);
      if (ntests == 0) begin
        $display("the pattern file holds no tests");
        err_other++;
      end
    end
    finish_run();
  end

endmodule

`default_nettype wire

// ==== la_top.f ====
+incdir+logic
logic/la_capture_pkg.sv
logic/la_video_pkg.sv
logic/la_rate_div.sv
logic/la_sample_ctrl.sv
logic/la_grid_overlay.sv
logic/la_wave_overlay.sv
logic/la_top.sv
test/tb_la_top.sv

// ==== Makefile ====
# Verilator build and run for the logic analyser testbench

VERILATOR ?= verilator
TOP       ?= tb_la_top
FILELIST  ?= la_top.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= Done: no errors

SIM_BIN = $(BUILD)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell sed -n 's/^\([^+].*\)$$/\1/p' $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

// ==== test/la_patterns.txt ====
# one capture per line: rate_sel trig_mode channel pre_num, all hex
# trig_mode 0 now, 1 rise, 2 fall, 3 high, 4 low, other codes act as now
0 0 0 000
1 0 3 040
2 0 5 200
0 1 2 010
1 1 7 064
0 1 0 000
2 2 4 020
0 2 1 3ff
0 3 6 030
1 4 1 008
2 3 0 000
0 5 2 020
0 4 7 3fe
